/* bench/tb_hps_fifo_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_hps_fifo_engine;

	// Test sizes
	localparam int N_PAIRS  = 12;
	localparam int N_ROUNDS = 5;
	localparam int N_ECHO   = 24;
	// 40 cycles per queued command or echo word, plus 100
	localparam int TIMEOUT_CYCLES = 40 * (1 + 2 * N_PAIRS + 4 * N_ROUNDS + N_ECHO) + 100;

	logic CLOCK_50 = 1'b0;
	logic reset    = 1'b1;

	fifo_pkg::fifo_src_t  cmd_src    = '{data: '0, empty: 1'b1};
	fifo_pkg::fifo_src_t  spike0_src = '{data: '0, empty: 1'b1};
	fifo_pkg::fifo_src_t  spike1_src = '{data: '0, empty: 1'b1};
	fifo_pkg::fifo_src_t  echo_src   = '{data: '0, empty: 1'b1};
	logic                 cmd_read;
	logic                 spike0_read;
	logic                 spike1_read;
	logic                 echo_read;
	fifo_pkg::fifo_sink_t result_sink;
	fifo_pkg::fifo_sink_t echo_sink;

	// ==============================
	// FIFO models and scoreboard
	// ==============================
	fifo_pkg::word_t cmd_q [$];
	fifo_pkg::word_t spike0_q [$];
	fifo_pkg::word_t spike1_q [$];
	fifo_pkg::word_t echo_q [$];
	fifo_pkg::word_t exp_result [$];
	fifo_pkg::word_t exp_echo [$];

	// Read strobes seen at the last rising edge, cmd/spike0/spike1/echo
	logic [3:0] pop_flags = 4'b0;
	logic       reset_q   = 1'b0;
	logic       reset_qq  = 1'b0;

	// Expected store contents, follows every fetch sent
	fifo_pkg::spike_pair_t shadow = '0;

	int cmd_pushes    = 0;
	int cmd_pops      = 0;
	int spike0_pushes = 0;
	int spike0_pops   = 0;
	int spike1_pushes = 0;
	int spike1_pops   = 0;
	int echo_pushes   = 0;
	int echo_pops     = 0;
	int mismatch_count = 0;
	int fault_count    = 0;
	int cycle_count    = 0;

	logic [31:0] lfsr_state = 32'd67146;

	// Galois LFSR, right shift, one step per bit
	function automatic fifo_pkg::word_t random_bits(input int n);
		fifo_pkg::word_t w;
		logic            b;
		w = '0;
		for (int k = 0; k < n; k++)
		begin
			b          = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (b)
				lfsr_state = lfsr_state ^ 32'hA300_0000;
			w = {w[30:0], b};
		end
		return w;
	endfunction

	// Random code that is neither emit nor fetch, small ones included
	function automatic fifo_pkg::word_t bad_code();
		fifo_pkg::word_t c;
		if (random_bits(1) == 1)
			c = random_bits(3);
		else
			c = random_bits(32);
		if (c == cmd_pkg::CMD_EMIT || c == cmd_pkg::CMD_FETCH)
			c = c ^ 32'h8000_0000;
		return c;
	endfunction

	// Reference: hi plus lo, wrapped to one word
	function automatic fifo_pkg::word_t expected_sum(input fifo_pkg::spike_pair_t p);
		fifo_pkg::word_t s;
		s = p.hi + p.lo;
		return s;
	endfunction

	task automatic check_result(input fifo_pkg::fifo_sink_t got, input fifo_pkg::word_t exp);
		if (got.data !== exp)
		begin
			mismatch_count++;
			$display("MISMATCH at %0t: result word %h, expected %h", $time, got.data, exp);
		end
	endtask

	task automatic check_echo(input fifo_pkg::fifo_sink_t got, input fifo_pkg::word_t exp);
		if (got.data !== exp)
		begin
			mismatch_count++;
			$display("MISMATCH at %0t: echo word %h, expected %h", $time, got.data, exp);
		end
	endtask

	task automatic check_idle(input logic [3:0] reads, input fifo_pkg::fifo_sink_t result,
		input fifo_pkg::fifo_sink_t echo);
		if (reads !== 4'b0 || result.write !== 1'b0 || echo.write !== 1'b0)
		begin
			mismatch_count++;
			$display("MISMATCH at %0t: strobes around reset reads %b result %b echo %b",
				$time, reads, result.write, echo.write);
		end
	endtask

	task automatic compare_counts(input string name, input int pops, input int pushes);
		if (pops != pushes)
		begin
			fault_count++;
			$display("The %s FIFO saw %0d reads for %0d pushed words", name, pops, pushes);
		end
	endtask

	task automatic send_fetch(input fifo_pkg::word_t lo_word, input fifo_pkg::word_t hi_word);
		spike0_q.push_back(lo_word);
		spike0_pushes++;
		spike1_q.push_back(hi_word);
		spike1_pushes++;
		cmd_q.push_back(cmd_pkg::CMD_FETCH);
		cmd_pushes++;
		shadow.lo = lo_word;
		shadow.hi = hi_word;
	endtask

	task automatic send_emit();
		cmd_q.push_back(cmd_pkg::CMD_EMIT);
		cmd_pushes++;
		exp_result.push_back(expected_sum(shadow));
	endtask

	task automatic send_bad();
		cmd_q.push_back(bad_code());
		cmd_pushes++;
	endtask

	// Until every model is empty and every expected word was seen
	task automatic wait_drained();
		while (cmd_q.size() != 0 || spike0_q.size() != 0 || spike1_q.size() != 0
			|| echo_q.size() != 0 || exp_result.size() != 0 || exp_echo.size() != 0)
			@(posedge CLOCK_50);
		repeat (10) @(posedge CLOCK_50);
	endtask

	hps_fifo_engine hps_fifo_engine_i (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.cmd_src     (cmd_src),
		.spike0_src  (spike0_src),
		.spike1_src  (spike1_src),
		.echo_src    (echo_src),
		.cmd_read    (cmd_read),
		.spike0_read (spike0_read),
		.spike1_read (spike1_read),
		.echo_read   (echo_read),
		.result_sink (result_sink),
		.echo_sink   (echo_sink)
	);

	always #2 CLOCK_50 = ~CLOCK_50;

	// ==============================
	// Source drive, falling edge
	// ==============================
	always @(negedge CLOCK_50)
	begin
		// Popped word shows one cycle after its strobe
		if (pop_flags[3])
		begin
			cmd_pops++;
			if (cmd_q.size() != 0)
				cmd_src.data <= cmd_q.pop_front();
		end
		if (pop_flags[2])
		begin
			spike0_pops++;
			if (spike0_q.size() != 0)
				spike0_src.data <= spike0_q.pop_front();
		end
		if (pop_flags[1])
		begin
			spike1_pops++;
			if (spike1_q.size() != 0)
				spike1_src.data <= spike1_q.pop_front();
		end
		if (pop_flags[0])
		begin
			echo_pops++;
			if (echo_q.size() != 0)
				echo_src.data <= echo_q.pop_front();
		end
		cmd_src.empty    <= (cmd_q.size() == 0);
		spike0_src.empty <= (spike0_q.size() == 0);
		spike1_src.empty <= (spike1_q.size() == 0);
		echo_src.empty   <= (echo_q.size() == 0);
	end

	// ==============================
	// Strobe sampling and compare, rising edge
	// ==============================
	always @(posedge CLOCK_50)
	begin
		reset_q   <= reset;
		reset_qq  <= reset_q;
		pop_flags <= {cmd_read, spike0_read, spike1_read, echo_read};
		if (reset_q || reset_qq)
			check_idle({cmd_read, spike0_read, spike1_read, echo_read}, result_sink, echo_sink);
		else if (!reset)
		begin
			if (cmd_read && cmd_src.empty)
			begin
				fault_count++;
				$display("Command FIFO was read while empty at %0t", $time);
			end
			if (echo_read && echo_src.empty)
			begin
				fault_count++;
				$display("Echo FIFO was read while empty at %0t", $time);
			end
			if (result_sink.write)
			begin
				if (exp_result.size() == 0)
				begin
					fault_count++;
					$display("Result FIFO got a write nobody asked for at %0t", $time);
				end
				else
					check_result(result_sink, exp_result.pop_front());
			end
			if (echo_sink.write)
			begin
				if (exp_echo.size() == 0)
				begin
					fault_count++;
					$display("Echo output got an extra write at %0t", $time);
				end
				else
					check_echo(echo_sink, exp_echo.pop_front());
			end
		end
	end

	// Run limit
	always @(posedge CLOCK_50)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Run stopped after %0d cycles, traffic never drained", cycle_count);
			$display("Errors: %0d mismatches, %0d other", mismatch_count, fault_count + 1);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// ==============================
	// Stimulus
	// ==============================
	initial
	begin
		fifo_pkg::word_t lo_word;
		fifo_pkg::word_t hi_word;
		repeat (4) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		reset = 1'b0;
		repeat (2) @(posedge CLOCK_50);
		// Cleared store, sum is zero
		send_emit();
		wait_drained();
		// Echo stream alongside the fetch and emit pairs
		for (int i = 0; i < N_ECHO; i++)
		begin
			lo_word = random_bits(32);
			echo_q.push_back(lo_word);
			echo_pushes++;
			exp_echo.push_back(lo_word);
		end
		for (int i = 0; i < N_PAIRS; i++)
		begin
			lo_word = random_bits(32);
			hi_word = random_bits(32);
			send_fetch(lo_word, hi_word);
			send_emit();
		end
		wait_drained();
		// Junk codes mixed into valid traffic
		for (int i = 0; i < N_ROUNDS; i++)
		begin
			send_bad();
			lo_word = random_bits(32);
			hi_word = random_bits(32);
			send_fetch(lo_word, hi_word);
			send_bad();
			send_emit();
		end
		wait_drained();
		repeat (20) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		compare_counts("command", cmd_pops, cmd_pushes);
		compare_counts("spike 0", spike0_pops, spike0_pushes);
		compare_counts("spike 1", spike1_pops, spike1_pushes);
		compare_counts("echo", echo_pops, echo_pushes);
		$display("Errors: %0d mismatches, %0d other", mismatch_count, fault_count);
		if (mismatch_count == 0 && fault_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
common/fifo_pkg.sv
common/cmd_pkg.sv
sequencer/spike_store.sv
sequencer/spike_fetcher.sv
sequencer/command_sequencer.sv
design/echo_forwarder.sv
design/hps_fifo_engine.sv
bench/tb_hps_fifo_engine.sv

/* common/cmd_pkg.sv */
`default_nettype none

// ==============================
// Command path codes and states
// ==============================
package cmd_pkg;

	// Command codes from the command FIFO
	localparam fifo_pkg::word_t CMD_EMIT  = 32'd1;
	localparam fifo_pkg::word_t CMD_FETCH = 32'd2;

	// Cycles from read strobe to valid source data
	localparam int READ_LATENCY = 1;

	// Command sequencer
	typedef enum logic [2:0] {
		SEQ_IDLE, SEQ_READ, SEQ_LOAD, SEQ_DECODE, SEQ_WAIT
	} seq_state_t;

	// Spike fetch sequence
	typedef enum logic [2:0] {
		FETCH_IDLE, FETCH_READ0, FETCH_READ1, FETCH_SETTLE, FETCH_DONE
	} fetch_state_t;

endpackage

`default_nettype wire

/* common/fifo_pkg.sv */
`default_nettype none

// ==============================
// FIFO word and port types
// ==============================
package fifo_pkg;

	// Every FIFO in the design carries one 32-bit word
	localparam int WORD_W = 32;

	// One FIFO data word
	typedef logic [WORD_W-1:0] word_t;

	// Read side of a source FIFO, as seen by the fabric
	// Data is valid one cycle after the read strobe
	typedef struct packed {
		word_t data;
		logic  empty;
	} fifo_src_t;

	// Write side of a sink FIFO
	// One push per cycle with write high, never refused
	typedef struct packed {
		word_t data;
		logic  write;
	} fifo_sink_t;

	// Spike store layout
	// hi from spike FIFO 1, lo from spike FIFO 0
	typedef struct packed {
		word_t hi;
		word_t lo;
	} spike_pair_t;

endpackage

`default_nettype wire

/* design/echo_forwarder.sv */
`timescale 1ns/1ps
`default_nettype none

module echo_forwarder (
	input  logic                 CLOCK_50,
	input  logic                 reset,
	input  fifo_pkg::fifo_src_t  echo_src,
	output logic                 echo_read,
	output fifo_pkg::fifo_sink_t echo_sink
);

	// Read state, one bit per stage
	logic read_q;
	logic capture_q;

	// Word waiting for the sink
	logic            write_pending;
	fifo_pkg::word_t hold_word;

	logic start_read;

	// New read only with nothing in flight
	assign start_read = !echo_src.empty && !read_q && !capture_q && !write_pending;

	// ==============================
	// Read, capture, write
	// ==============================
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			read_q        <= 1'b0;
			capture_q     <= 1'b0;
			write_pending <= 1'b0;
		end
		else
		begin
			read_q        <= start_read;
			// Data valid the cycle after the strobe
			capture_q     <= read_q;
			write_pending <= capture_q;
		end
	end

	// Hold register
	always_ff @(posedge CLOCK_50)
	begin
		if (capture_q)
			hold_word <= echo_src.data;
	end

	assign echo_read       = read_q;
	assign echo_sink.data  = hold_word;
	assign echo_sink.write = write_pending;

	// Never pop an empty echo FIFO
	a_no_read_empty: assert property (@(posedge CLOCK_50) disable iff (reset)
		echo_read |-> !echo_src.empty);

endmodule

`default_nettype wire

/* design/hps_fifo_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module hps_fifo_engine (
	input  logic                 CLOCK_50,
	input  logic                 reset,
	input  fifo_pkg::fifo_src_t  cmd_src,
	input  fifo_pkg::fifo_src_t  spike0_src,
	input  fifo_pkg::fifo_src_t  spike1_src,
	input  fifo_pkg::fifo_src_t  echo_src,
	output logic                 cmd_read,
	output logic                 spike0_read,
	output logic                 spike1_read,
	output logic                 echo_read,
	output fifo_pkg::fifo_sink_t result_sink,
	output fifo_pkg::fifo_sink_t echo_sink
);

	// Sequencer to fetcher handshake
	logic fetch_start;
	logic fetch_done;

	// Fetcher to store
	logic load_lo;
	logic load_hi;

	// ==============================
	// Command path
	// ==============================
	command_sequencer command_sequencer_i (
		.CLOCK_50     (CLOCK_50),
		.reset        (reset),
		.cmd_src      (cmd_src),
		.cmd_read     (cmd_read),
		.fetch_start  (fetch_start),
		.fetch_done   (fetch_done),
		.result_write (result_sink.write)
	);

	spike_fetcher spike_fetcher_i (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.start       (fetch_start),
		.spike0_read (spike0_read),
		.spike1_read (spike1_read),
		.load_lo     (load_lo),
		.load_hi     (load_hi),
		.done        (fetch_done)
	);

	// Spike data bypasses the fetcher
	spike_store spike_store_i (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.load_lo     (load_lo),
		.load_hi     (load_hi),
		.spike0_data (spike0_src.data),
		.spike1_data (spike1_src.data),
		.result_data (result_sink.data)
	);

	// ==============================
	// Echo path
	// ==============================
	echo_forwarder echo_forwarder_i (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.echo_src  (echo_src),
		.echo_read (echo_read),
		.echo_sink (echo_sink)
	);

endmodule

`default_nettype wire

/* sequencer/command_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module command_sequencer (
	input  logic                CLOCK_50,
	input  logic                reset,
	input  fifo_pkg::fifo_src_t cmd_src,
	output logic                cmd_read,
	output logic                fetch_start,
	input  logic                fetch_done,
	output logic                result_write
);

	cmd_pkg::seq_state_t state;
	cmd_pkg::seq_state_t state_next;

	// Last command word popped
	fifo_pkg::word_t cmd_buffer;

	logic load_cmd;
	logic emit_now;
	logic emit_pulse;

	// ==============================
	// State register
	// ==============================
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
			state <= cmd_pkg::SEQ_IDLE;
		else
			state <= state_next;
	end

	// ==============================
	// Next state and strobes
	// ==============================
	always_comb
	begin
		state_next  = state;
		cmd_read    = 1'b0;
		load_cmd    = 1'b0;
		fetch_start = 1'b0;
		emit_now    = 1'b0;
		case (state)
			// Poll the empty flag
			cmd_pkg::SEQ_IDLE:
				if (!cmd_src.empty)
					state_next = cmd_pkg::SEQ_READ;
			// Pop one word
			cmd_pkg::SEQ_READ:
			begin
				cmd_read   = 1'b1;
				state_next = cmd_pkg::SEQ_LOAD;
			end
			// Word shows up one cycle after the pop
			cmd_pkg::SEQ_LOAD:
			begin
				load_cmd   = 1'b1;
				state_next = cmd_pkg::SEQ_DECODE;
			end
			cmd_pkg::SEQ_DECODE:
			begin
				if (cmd_buffer == cmd_pkg::CMD_FETCH)
				begin
					fetch_start = 1'b1;
					state_next  = cmd_pkg::SEQ_WAIT;
				end
				else if (cmd_buffer == cmd_pkg::CMD_EMIT)
				begin
					emit_now   = 1'b1;
					state_next = cmd_pkg::SEQ_WAIT;
				end
				else
					// Unknown code, drop it
					state_next = cmd_pkg::SEQ_IDLE;
			end
			// Hold until the fetch or the emit is through
			cmd_pkg::SEQ_WAIT:
				if (fetch_done || emit_pulse)
					state_next = cmd_pkg::SEQ_IDLE;
			default:
				state_next = cmd_pkg::SEQ_IDLE;
		endcase
	end

	// Command buffer
	always_ff @(posedge CLOCK_50)
	begin
		if (load_cmd)
			cmd_buffer <= cmd_src.data;
	end

	// Emit delay, result write lands 4 cycles after the pop
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			emit_pulse   <= 1'b0;
			result_write <= 1'b0;
		end
		else
		begin
			emit_pulse   <= emit_now;
			result_write <= emit_pulse;
		end
	end

	// Never pop an empty command FIFO
	a_no_read_empty: assert property (@(posedge CLOCK_50) disable iff (reset)
		cmd_read |-> !cmd_src.empty);

	// Fetch and emit never overlap
	a_fetch_emit_excl: assert property (@(posedge CLOCK_50) disable iff (reset)
		!(fetch_start && result_write));

endmodule

`default_nettype wire

/* sequencer/spike_fetcher.sv */
`timescale 1ns/1ps
`default_nettype none

module spike_fetcher (
	input  logic CLOCK_50,
	input  logic reset,
	input  logic start,
	output logic spike0_read,
	output logic spike1_read,
	output logic load_lo,
	output logic load_hi,
	output logic done
);

	cmd_pkg::fetch_state_t state;
	cmd_pkg::fetch_state_t state_next;

	// ==============================
	// State register
	// ==============================
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
			state <= cmd_pkg::FETCH_IDLE;
		else
			state <= state_next;
	end

	// Fixed walk through the two reads
	always_comb
	begin
		state_next = state;
		case (state)
			cmd_pkg::FETCH_IDLE:
				if (start)
					state_next = cmd_pkg::FETCH_READ0;
			cmd_pkg::FETCH_READ0:
				state_next = cmd_pkg::FETCH_READ1;
			cmd_pkg::FETCH_READ1:
				state_next = cmd_pkg::FETCH_SETTLE;
			// Last load strobe goes out here
			cmd_pkg::FETCH_SETTLE:
				state_next = cmd_pkg::FETCH_DONE;
			cmd_pkg::FETCH_DONE:
				state_next = cmd_pkg::FETCH_IDLE;
			default:
				state_next = cmd_pkg::FETCH_IDLE;
		endcase
	end

	// Read strobes and done decode straight from state
	assign spike0_read = (state == cmd_pkg::FETCH_READ0);
	assign spike1_read = (state == cmd_pkg::FETCH_READ1);
	assign done        = (state == cmd_pkg::FETCH_DONE);

	// ==============================
	// Load strobes, one cycle behind each read
	// ==============================
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			load_lo <= 1'b0;
			load_hi <= 1'b0;
		end
		else
		begin
			load_lo <= spike0_read;
			load_hi <= spike1_read;
		end
	end

	// Sequencer must not restart a fetch in flight
	a_start_idle: assert property (@(posedge CLOCK_50) disable iff (reset)
		start |-> state == cmd_pkg::FETCH_IDLE);

endmodule

`default_nettype wire

/* sequencer/spike_store.sv */
`timescale 1ns/1ps
`default_nettype none

module spike_store (
	input  logic            CLOCK_50,
	input  logic            reset,
	input  logic            load_lo,
	input  logic            load_hi,
	input  fifo_pkg::word_t spike0_data,
	input  fifo_pkg::word_t spike1_data,
	output fifo_pkg::word_t result_data
);

	// 64-bit spike word
	fifo_pkg::spike_pair_t spikes;

	// ==============================
	// Store and sum
	// ==============================
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			spikes      <= '0;
			result_data <= '0;
		end
		else
		begin
			// Each half on its own strobe
			if (load_lo)
				spikes.lo <= spike0_data;
			if (load_hi)
				spikes.hi <= spike1_data;
			// Sum wraps at 32 bits
			// settles well before the next emit can reach the sink
			result_data <= spikes.hi + spikes.lo;
		end
	end

endmodule

`default_nettype wire
